/* src/nabp_pkg.sv */
package nabp_pkg;

    // frame geometry
    localparam int k_no_of_s          = 16;
    localparam int k_no_of_angles     = 4;
    localparam int k_no_of_partitions = 2;
    localparam int k_pixels_per_pe    = 8;
    // image row spans all partitions
    localparam int k_no_of_pixels     = k_no_of_partitions * k_pixels_per_pe;

    // datapath widths
    localparam int k_data_length          = 12;
    localparam int k_filtered_data_length = 13;
    localparam int k_acc_length           = 18;

    typedef logic [$clog2(k_no_of_angles)-1:0]  angle_t;
    typedef logic [$clog2(k_no_of_s)-1:0]       s_t;
    typedef logic signed [k_data_length-1:0]    data_t;
    // one bit wider, holds any difference of two samples
    typedef logic signed [k_filtered_data_length-1:0] filtered_t;
    typedef logic [$clog2(k_no_of_pixels)-1:0]  pixel_t;
    // pixel index inside one PE
    typedef logic [$clog2(k_pixels_per_pe)-1:0] local_pixel_t;
    typedef logic signed [k_acc_length-1:0]     acc_t;

    // per bank state in the filtered RAM
    typedef enum logic [1:0] {
        fr_idle,
        fr_fill,
        fr_full
    } fr_state_e;

    // processing control
    typedef enum logic [1:0] {
        pr_idle,
        pr_clear,
        pr_scan,
        pr_release
    } pr_state_e;

endpackage

// full bank handed from the swap control to the processing control
interface nabp_bank_if import nabp_pkg::*; ();
    logic      req;
    logic      ack;
    angle_t    angle;
    s_t        rd_addr;
    filtered_t rd_data;

    modport owner (output req, input ack, output angle, input rd_addr, output rd_data);
    modport reader (input req, output ack, input angle, output rd_addr, input rd_data);
endinterface

// tap broadcast to the processing elements
interface nabp_pe_if import nabp_pkg::*; ();
    logic      clear;
    logic      en;
    angle_t    angle;
    s_t        s;
    filtered_t tap;

    modport ctrl (output clear, output en, output angle, output s, output tap);
    modport pe (input clear, input en, input angle, input s, input tap);
endinterface

/* src/nabp_filter.sv */
module nabp_filter import nabp_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      smp_valid,
    input  logic      smp_first,
    input  data_t     smp_val,
    output logic      filt_valid,
    output filtered_t filt_val
);

    // last sample of the current angle
    data_t     prev_q;
    // previous sample, forced to zero at angle start
    filtered_t prev_ext;
    filtered_t diff;

    assign prev_ext = smp_first ? filtered_t'(0) : filtered_t'(prev_q);
    // sign extend before subtracting, no overflow in 13 bits
    assign diff     = filtered_t'(smp_val) - prev_ext;

    // valid bit follows the input by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            filt_valid <= 1'b0;
        end else begin
            filt_valid <= smp_valid;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (smp_valid) begin
            prev_q   <= smp_val;
            filt_val <= diff;
        end
    end

endmodule

/* src/nabp_filtered_ram_swap_control.sv */
module nabp_filtered_ram_swap_control import nabp_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    // sinogram handshake
    input  logic       sino_req,
    output logic       sino_ack,
    input  angle_t     sino_angle,
    input  data_t      sino_val,
    // towards the filter
    output logic       smp_valid,
    output logic       smp_first,
    output data_t      smp_val,
    // back from the filter
    input  logic       filt_valid,
    input  filtered_t  filt_val,
    // full bank to the processing control
    nabp_bank_if.owner bank
);

    // two banks, one fills while the other is scanned
    filtered_t mem [2][k_no_of_s];
    fr_state_e state [2];
    angle_t    bank_angle [2];

    // bank being filled
    logic fill_sel;
    // next bank offered to the reader, follows fill order
    logic rd_sel;
    // all 16 samples of the fill bank captured
    logic cap_done;
    // s position of the next captured sample
    s_t   cap_cnt;
    // write address, lags cap_cnt by the filter delay
    s_t   wr_ptr;
    logic accept;
    logic last_write;
    logic bank_done;

    // no capture once the fill bank has its samples
    assign accept     = sino_req && !sino_ack && !cap_done && (state[fill_sel] != fr_full);
    assign last_write = filt_valid && (wr_ptr == s_t'(k_no_of_s - 1));
    assign bank_done  = bank.req && bank.ack;

    // four phase sinogram port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sino_ack  <= 1'b0;
            smp_valid <= 1'b0;
        end else begin
            smp_valid <= accept;
            if (accept) begin
                sino_ack <= 1'b1;
            end else if (!sino_req) begin
                sino_ack <= 1'b0;
            end
        end
    end

    // sample captured on the ack edge
    always_ff @(posedge clk) begin
        if (accept) begin
            smp_val   <= sino_val;
            smp_first <= (cap_cnt == '0);
        end
    end

    // bank bookkeeping
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state[0]      <= fr_idle;
            state[1]      <= fr_idle;
            bank_angle[0] <= '0;
            bank_angle[1] <= '0;
            fill_sel      <= 1'b0;
            rd_sel        <= 1'b0;
            cap_done      <= 1'b0;
            cap_cnt       <= '0;
            wr_ptr        <= '0;
            bank.req      <= 1'b0;
        end else begin
            if (accept) begin
                cap_cnt <= cap_cnt + 1'b1;
                // first sample opens the bank and tags its angle
                if (cap_cnt == '0) begin
                    state[fill_sel]      <= fr_fill;
                    bank_angle[fill_sel] <= sino_angle;
                end
                if (cap_cnt == s_t'(k_no_of_s - 1)) begin
                    cap_done <= 1'b1;
                end
            end
            if (filt_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (last_write) begin
                state[fill_sel] <= fr_full;
            end
            // move filling to the other bank once it is free
            if ((state[fill_sel] == fr_full) && (state[~fill_sel] == fr_idle)) begin
                fill_sel <= ~fill_sel;
                cap_done <= 1'b0;
            end
            // offer the oldest full bank, reader must be idle
            if (!bank.req && !bank.ack && (state[rd_sel] == fr_full)) begin
                bank.req <= 1'b1;
            end else if (bank_done) begin
                // scan finished, bank returns to the pool
                bank.req      <= 1'b0;
                state[rd_sel] <= fr_idle;
                rd_sel        <= ~rd_sel;
            end
        end
    end

    // filtered row memory
    always_ff @(posedge clk) begin
        if (filt_valid) begin
            mem[fill_sel][wr_ptr] <= filt_val;
        end
    end

    // read side, combinational from the offered bank
    assign bank.rd_data = mem[rd_sel][bank.rd_addr];
    assign bank.angle   = bank_angle[rd_sel];

endmodule

/* src/nabp_processing_swap_control.sv */
module nabp_processing_swap_control import nabp_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // full bank from the swap control
    nabp_bank_if.reader bank,
    // tap bus to the PEs
    nabp_pe_if.ctrl     pe,
    output logic        frame_done
);

    pr_state_e state;
    // scan position, also the bank read address
    s_t        s_cnt;
    // angle of the bank being scanned
    angle_t    cur_angle;
    logic      last_s;
    logic      last_angle;

    assign last_s     = (s_cnt == s_t'(k_no_of_s - 1));
    assign last_angle = (cur_angle == angle_t'(k_no_of_angles - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= pr_idle;
            s_cnt      <= '0;
            cur_angle  <= '0;
            frame_done <= 1'b0;
        end else begin
            // single cycle pulse
            frame_done <= 1'b0;
            case (state)
                pr_idle: begin
                    if (bank.req) begin
                        cur_angle <= bank.angle;
                        s_cnt     <= '0;
                        // angle 0 starts a frame, accumulators cleared first
                        if (bank.angle == '0) begin
                            state <= pr_clear;
                        end else begin
                            state <= pr_scan;
                        end
                    end
                end
                pr_clear: begin
                    state <= pr_scan;
                end
                pr_scan: begin
                    s_cnt <= s_cnt + 1'b1;
                    if (last_s) begin
                        state      <= pr_release;
                        // last add lands on this edge
                        frame_done <= last_angle;
                    end
                end
                pr_release: begin
                    // ack held until the owner drops req
                    if (!bank.req) begin
                        state <= pr_idle;
                    end
                end
                default: begin
                    state <= pr_idle;
                end
            endcase
        end
    end

    // bank side
    assign bank.rd_addr = s_cnt;
    assign bank.ack     = (state == pr_release);

    // tap bus, tap is the bank value at s
    assign pe.clear = (state == pr_clear);
    assign pe.en    = (state == pr_scan);
    assign pe.angle = cur_angle;
    assign pe.s     = s_cnt;
    assign pe.tap   = bank.rd_data;

endmodule

/* src/nabp_processing_element.sv */
module nabp_processing_element import nabp_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    // tap bus, s already relative to this partition
    nabp_pe_if.pe        pe,
    // readout
    input  local_pixel_t rd_pixel,
    output acc_t         rd_val
);

    // one accumulator per pixel of the partition
    acc_t         acc [k_pixels_per_pe];
    // sheared pixel index, wraps mod 16
    s_t           rel;
    local_pixel_t local_pix;
    logic         hit;
    acc_t         tap_ext;

    // pixel p takes s = p + angle, so p = s - angle
    assign rel       = pe.s - s_t'(pe.angle);
    // upper half of the wrap belongs to the other partition
    assign hit       = pe.en && (rel < s_t'(k_pixels_per_pe));
    assign local_pix = local_pixel_t'(rel);
    assign tap_ext   = acc_t'(pe.tap);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < k_pixels_per_pe; i++) begin
                acc[i] <= '0;
            end
        end else if (pe.clear) begin
            // new frame
            for (int i = 0; i < k_pixels_per_pe; i++) begin
                acc[i] <= '0;
            end
        end else if (hit) begin
            acc[local_pix] <= acc[local_pix] + tap_ext;
        end
    end

    // readout mux
    assign rd_val = acc[rd_pixel];

endmodule

/* src/nabp.sv */
module nabp import nabp_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    // sinogram input
    input  logic   sino_req,
    output logic   sino_ack,
    input  angle_t sino_angle,
    input  data_t  sino_val,
    // image readout
    input  logic   img_req,
    output logic   img_ack,
    input  pixel_t img_addr,
    output acc_t   img_data,
    output logic   frame_done
);

    // filter path
    logic      smp_valid;
    logic      smp_first;
    data_t     smp_val;
    logic      filt_valid;
    filtered_t filt_val;

    // readout values from each PE
    acc_t      rd_val [k_no_of_partitions];

    nabp_bank_if bank ();
    nabp_pe_if   pe_bus ();

    nabp_filter i_filter (
        .clk        (clk),
        .rst_n      (rst_n),
        .smp_valid  (smp_valid),
        .smp_first  (smp_first),
        .smp_val    (smp_val),
        .filt_valid (filt_valid),
        .filt_val   (filt_val)
    );

    nabp_filtered_ram_swap_control i_filtered_ram_swap_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .sino_req   (sino_req),
        .sino_ack   (sino_ack),
        .sino_angle (sino_angle),
        .sino_val   (sino_val),
        .smp_valid  (smp_valid),
        .smp_first  (smp_first),
        .smp_val    (smp_val),
        .filt_valid (filt_valid),
        .filt_val   (filt_val),
        .bank       (bank.owner)
    );

    nabp_processing_swap_control i_processing_swap_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .bank       (bank.reader),
        .pe         (pe_bus.ctrl),
        .frame_done (frame_done)
    );

    for (genvar g = 0; g < k_no_of_partitions; g++) begin : g_pe
        // first image pixel of this partition
        localparam int k_offset = g * k_pixels_per_pe;

        // bus copy with s shifted by the partition offset
        nabp_pe_if pe_part ();

        assign pe_part.clear = pe_bus.clear;
        assign pe_part.en    = pe_bus.en;
        assign pe_part.angle = pe_bus.angle;
        assign pe_part.s     = pe_bus.s - s_t'(k_offset);
        assign pe_part.tap   = pe_bus.tap;

        nabp_processing_element i_processing_element (
            .clk      (clk),
            .rst_n    (rst_n),
            .pe       (pe_part.pe),
            .rd_pixel (local_pixel_t'(img_addr)),
            .rd_val   (rd_val[g])
        );
    end

    // four phase readout, top address bit picks the PE
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            img_ack <= 1'b0;
        end else if (img_req && !img_ack) begin
            img_ack <= 1'b1;
        end else if (!img_req) begin
            img_ack <= 1'b0;
        end
    end

    // data register loads with the ack
    always_ff @(posedge clk) begin
        if (img_req && !img_ack) begin
            img_data <= rd_val[img_addr[$bits(pixel_t)-1]];
        end
    end

endmodule

/* dv/nabp_sva.sv */
module nabp_sva import nabp_pkg::*; (
    input logic   clk,
    input logic   rst_n,
    input logic   req,
    input logic   ack,
    input logic   en,
    input logic   clear,
    input angle_t angle
);
    timeunit 1ns;
    timeprecision 100ps;

    // failures per rule, summed for the testbench
    int fail_req   = 0;
    int fail_ack   = 0;
    int fail_en    = 0;
    int fail_clear = 0;
    int fail_cnt;
    // length of the current en run
    logic [4:0] en_run;

    assign fail_cnt = fail_req + fail_ack + fail_en + fail_clear;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_run <= '0;
        end else if (en) begin
            en_run <= en_run + 1'b1;
        end else begin
            en_run <= '0;
        end
    end

    // offered bank stays offered until the scan is acknowledged
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n) req && !ack |=> req)
        else begin
            $error("bank req dropped before ack");
            fail_req++;
        end

    // ack only answers a pending req
    a_ack_follows: assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> req)
        else begin
            $error("bank ack raised without req");
            fail_ack++;
        end

    // one full row per bank
    a_en_run: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(en) |-> (en_run == 5'(k_no_of_s)))
        else begin
            $error("en run of %0d cycles", en_run);
            fail_en++;
        end

    // accumulators cleared only at frame start
    a_clear_angle: assert property (@(posedge clk) disable iff (!rst_n)
        clear |-> (angle == '0))
        else begin
            $error("clear with angle %0d", angle);
            fail_clear++;
        end

endmodule

/* dv/nabp_checker.sv */
module nabp_checker import nabp_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sino_ack,
    input  angle_t      sino_angle,
    input  data_t       sino_val,
    input  logic        img_ack,
    input  pixel_t      img_addr,
    input  acc_t        img_data,
    input  logic        frame_done,
    // one tap leaves a bank per enabled cycle
    input  logic        scan_en,
    input  logic [95:0] test_name,
    output int          checks,
    output int          errors
);
    timeunit 1ns;
    timeprecision 100ps;

    // accepted samples of the current frame, per angle in arrival order
    int   raw [k_no_of_angles][k_no_of_s];
    int   raw_cnt [k_no_of_angles];
    int   expected [k_no_of_pixels];
    int   frame_cnt;
    // accepted but not yet scanned
    int   in_flight;
    logic sino_ack_d;
    logic img_ack_d;

    // difference to the previous sample, zero before s = 0
    function automatic int filtered(input int a, input int s);
        if (s == 0) begin
            return raw[a][0];
        end
        return raw[a][s] - raw[a][s - 1];
    endfunction

    // pixel p takes s = (p + angle) mod 16 from every angle
    function automatic void predict_image();
        for (int p = 0; p < k_no_of_pixels; p++) begin
            expected[p] = 0;
            for (int a = 0; a < k_no_of_angles; a++) begin
                expected[p] += filtered(a, (p + a) % k_no_of_s);
            end
        end
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            checks     = 0;
            errors     = 0;
            frame_cnt  = 0;
            in_flight  = 0;
            sino_ack_d = 1'b0;
            img_ack_d  = 1'b0;
            for (int a = 0; a < k_no_of_angles; a++) begin
                raw_cnt[a] = 0;
            end
        end else begin
            // ack rise marks an accepted sample
            if (sino_ack && !sino_ack_d) begin
                if (raw_cnt[sino_angle] < k_no_of_s) begin
                    raw[sino_angle][raw_cnt[sino_angle]] = int'(sino_val);
                    raw_cnt[sino_angle]++;
                end else begin
                    $display("%0s: too many samples accepted for angle %0d",
                             test_name, sino_angle);
                    errors++;
                end
                frame_cnt++;
                in_flight++;
            end
            if (scan_en) begin
                in_flight--;
            end
            // two banks hold at most 32 samples
            if (in_flight > 2 * k_no_of_s || in_flight < 0) begin
                $display("%0s: %0d samples held, more than two banks",
                         test_name, in_flight);
                errors++;
            end
            if (frame_done) begin
                if (frame_cnt != k_no_of_angles * k_no_of_s) begin
                    $display("mismatch %0s accepted samples expected %0d actual %0d",
                             test_name, k_no_of_angles * k_no_of_s, frame_cnt);
                    errors++;
                end
                predict_image();
                frame_cnt = 0;
                for (int a = 0; a < k_no_of_angles; a++) begin
                    raw_cnt[a] = 0;
                end
            end
            // img_data loads on the same edge as the ack
            if (img_ack && !img_ack_d) begin
                checks++;
                if (img_data !== acc_t'(expected[img_addr])) begin
                    $display("mismatch %0s pixel %0d expected %0d actual %0d",
                             test_name, img_addr, expected[img_addr], img_data);
                    errors++;
                end
            end
            sino_ack_d = sino_ack;
            img_ack_d  = img_ack;
        end
    end

endmodule

/* dv/nabp_tb.sv */
module nabp_tb import nabp_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int k_rows        = 6;
    // cycles for one handshake phase
    localparam int k_wait_limit  = 200;
    // cycles from the last sample to frame_done
    localparam int k_frame_limit = 500;

    logic   clk;
    logic   rst_n;
    logic   sino_req;
    logic   sino_ack;
    angle_t sino_angle;
    data_t  sino_val;
    logic   img_req;
    logic   img_ack;
    pixel_t img_addr;
    acc_t   img_data;
    logic   frame_done;

    // frames, ramp x = base + step * s on every angle unless random
    // sum column is 4 * x[15], the telescoped image sum of a ramp
    logic [95:0] row_name [k_rows] = '{"ramp_up", "ramp_down", "flat",
                                       "random_a", "random_b", "ramp_wide"};
    int row_base [k_rows] = '{100, -200, 500, 0, 0, -2000};
    int row_step [k_rows] = '{3, -7, 0, 0, 0, 250};
    bit row_rnd  [k_rows] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
    int row_sum  [k_rows] = '{580, -1220, 2000, 0, 0, 7000};

    logic [95:0] cur_name;
    logic [31:0] rng;
    bit          timed_out;
    int          tb_errors;
    int          checks;
    int          chk_errors;
    int          sva_fails;

    nabp i_nabp (
        .clk        (clk),
        .rst_n      (rst_n),
        .sino_req   (sino_req),
        .sino_ack   (sino_ack),
        .sino_angle (sino_angle),
        .sino_val   (sino_val),
        .img_req    (img_req),
        .img_ack    (img_ack),
        .img_addr   (img_addr),
        .img_data   (img_data),
        .frame_done (frame_done)
    );

    nabp_checker i_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .sino_ack   (sino_ack),
        .sino_angle (sino_angle),
        .sino_val   (sino_val),
        .img_ack    (img_ack),
        .img_addr   (img_addr),
        .img_data   (img_data),
        .frame_done (frame_done),
        .scan_en    (i_nabp.pe_bus.en),
        .test_name  (cur_name),
        .checks     (checks),
        .errors     (chk_errors)
    );

    // clear checked against the angle tag of the offered bank
    bind nabp_processing_swap_control nabp_sva i_nabp_sva (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (bank.req),
        .ack   (bank.ack),
        .en    (pe.en),
        .clear (pe.clear),
        .angle (bank.angle)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // later waits are skipped once one has expired
    task automatic flag_timeout(input string what);
        $display("timeout waiting for %s", what);
        tb_errors++;
        timed_out = 1'b1;
    endtask

    // inputs change 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_sample(input angle_t a, input data_t v);
        int n;
        if (timed_out) return;
        sino_angle = a;
        sino_val   = v;
        sino_req   = 1'b1;
        n = 0;
        while (!sino_ack && n < k_wait_limit) begin
            step_cycle();
            n++;
        end
        if (!sino_ack) begin
            flag_timeout("sino_ack to rise");
            return;
        end
        sino_req = 1'b0;
        n = 0;
        while (sino_ack && n < k_wait_limit) begin
            step_cycle();
            n++;
        end
        if (sino_ack) flag_timeout("sino_ack to fall");
    endtask

    task automatic send_frame(input int r);
        data_t v;
        for (int a = 0; a < k_no_of_angles; a++) begin
            for (int s = 0; s < k_no_of_s; s++) begin
                if (row_rnd[r]) begin
                    rng = xorshift(rng);
                    v   = data_t'(rng[11:0]);
                end else begin
                    v = data_t'(row_base[r] + row_step[r] * s);
                end
                send_sample(angle_t'(a), v);
            end
        end
    endtask

    task automatic wait_frame_done();
        int n;
        if (timed_out) return;
        n = 0;
        while (!frame_done && n < k_frame_limit) begin
            step_cycle();
            n++;
        end
        if (!frame_done) flag_timeout("frame_done");
    endtask

    // gap idles before req and before dropping req
    task automatic read_pixel(input pixel_t addr, input int gap, output acc_t val);
        int n;
        val = '0;
        if (timed_out) return;
        repeat (gap) step_cycle();
        img_addr = addr;
        img_req  = 1'b1;
        n = 0;
        while (!img_ack && n < k_wait_limit) begin
            step_cycle();
            n++;
        end
        if (!img_ack) begin
            flag_timeout("img_ack to rise");
            return;
        end
        val = img_data;
        repeat (gap) step_cycle();
        img_req = 1'b0;
        n = 0;
        while (img_ack && n < k_wait_limit) begin
            step_cycle();
            n++;
        end
        if (img_ack) flag_timeout("img_ack to fall");
    endtask

    initial begin
        acc_t px;
        int   sum;
        sino_req   = 1'b0;
        sino_angle = '0;
        sino_val   = '0;
        img_req    = 1'b0;
        img_addr   = '0;
        cur_name   = '0;
        rng        = 32'h77e8_dba4;
        timed_out  = 1'b0;
        tb_errors  = 0;
        rst_n      = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        step_cycle();
        // frames back to back, readout in between
        for (int r = 0; r < k_rows; r++) begin
            cur_name = row_name[r];
            send_frame(r);
            wait_frame_done();
            sum = 0;
            for (int p = 0; p < k_no_of_pixels; p++) begin
                read_pixel(pixel_t'(p), 0, px);
                sum += int'(px);
            end
            if (!row_rnd[r] && !timed_out && sum != row_sum[r]) begin
                $display("mismatch %0s image sum expected %0d actual %0d",
                         row_name[r], row_sum[r], sum);
                tb_errors++;
            end
            // second pass with random gaps, checker compares again
            for (int p = 0; p < k_no_of_pixels; p++) begin
                rng = xorshift(rng);
                read_pixel(pixel_t'(p), int'(rng[1:0]), px);
            end
        end
        sva_fails = i_nabp.i_processing_swap_control.i_nabp_sva.fail_cnt;
        $display("checks %0d, checker errors %0d, testbench errors %0d, assertion failures %0d",
                 checks, chk_errors, tb_errors, sva_fails);
        if (checks == 2 * k_rows * k_no_of_pixels &&
            chk_errors + tb_errors + sva_fails == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* nabp.f */
src/nabp_pkg.sv
src/nabp_filter.sv
src/nabp_filtered_ram_swap_control.sv
src/nabp_processing_swap_control.sv
src/nabp_processing_element.sv
src/nabp.sv
dv/nabp_sva.sv
dv/nabp_checker.sv
dv/nabp_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the nabp testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module nabp_tb -f nabp.f -o nabp_sim

# assertion errors must not stop the run before the final report
./obj_dir/nabp_sim +verilator+error+limit+100 | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
